// ==== tb.f ====
+incdir+source
+incdir+test
source/cpuPkg.sv
source/aluCore.sv
source/fetchSequencer.sv
source/instrBuffer.sv
source/executeUnit.sv
source/cpuTop.sv
test/tbCpu.sv

// ==== Bender.yml ====
package:
  name: cpu8

export_include_dirs:
  - source

sources:
  - files:
      - source/cpuPkg.sv
      - source/aluCore.sv
      - source/fetchSequencer.sv
      - source/instrBuffer.sv
      - source/executeUnit.sv
      - source/cpuTop.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tbCpu.sv

// ==== test/tbProgram.svh ====
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// Register codes as they appear in instruction fields
localparam logic [2:0] codeR1 = 3'd0;
localparam logic [2:0] codeR2 = 3'd1;
localparam logic [2:0] codeR3 = 3'd2;
localparam logic [2:0] codeR4 = 3'd3;
localparam logic [2:0] codeAr = 3'd5;
localparam logic [2:0] codePc = 3'd6;

function automatic logic [7:0] randomByte();
    logic [31:0] value;
    value = $random(seed);
    return value[7:0];
endfunction

function automatic logic [15:0] aluWord(input cpuPkg::opcodeE op, input logic [2:0] dest,
                                        input logic [2:0] src1, input logic [2:0] src2);
    return {op, 1'b0, dest, 1'b0, src1, 1'b0, src2};
endfunction

function automatic logic [15:0] ldImmWord(input logic [1:0] r, input logic [7:0] imm);
    return {cpuPkg::OP_LD, 2'b00, r, imm};
endfunction

// LD or ST through M[AR]
function automatic logic [15:0] directWord(input cpuPkg::opcodeE op, input logic [1:0] r);
    return {op, 2'b01, r, 8'h00};
endfunction

function automatic logic [15:0] branchWord(input cpuPkg::opcodeE op, input logic [7:0] target);
    return {op, 4'h0, target};
endfunction

function automatic void emit(input logic [15:0] word);
    mem[progPc]        = word[15:8];    // High byte first
    mem[progPc + 8'd1] = word[7:0];
    progPc             = progPc + 8'd2;
endfunction

task automatic buildProgram();
    cpuPkg::opcodeE aluOps [10];
    int i;
    aluOps = '{cpuPkg::OP_AND, cpuPkg::OP_OR, cpuPkg::OP_NOT, cpuPkg::OP_ADD, cpuPkg::OP_SUB,
               cpuPkg::OP_LSL, cpuPkg::OP_LSR, cpuPkg::OP_MOV, cpuPkg::OP_INC, cpuPkg::OP_DEC};
    for (i = 0; i < `MEM_DEPTH; i++) begin
        mem[i] = i[7:0] ^ 8'h5a;
    end
    for (i = 'hc0; i < `MEM_DEPTH; i++) begin
        mem[i] = randomByte();          // Data area
    end
    progPc = '0;
    emit(ldImmWord(2'd0, randomByte()));
    emit(ldImmWord(2'd1, randomByte()));
    emit(ldImmWord(2'd3, 8'hc0));
    emit(aluWord(cpuPkg::OP_MOV, codeAr, codeR4, codeR1));
    emit(directWord(cpuPkg::OP_ST, 2'd0));
    emit(aluWord(cpuPkg::OP_INC, codeAr, codeAr, codeR1));
    emit(directWord(cpuPkg::OP_ST, 2'd1));
    emit(aluWord(cpuPkg::OP_INC, codeAr, codeAr, codeR1));
    emit(directWord(cpuPkg::OP_LD, 2'd2));
    emit(aluWord(cpuPkg::OP_INC, codeAr, codeAr, codeR1));
    emit(directWord(cpuPkg::OP_ST, 2'd2));
    for (i = 0; i < 10; i++) begin
        emit(aluWord(aluOps[i], codeR3, codeR1, codeR2));
        emit(aluWord(cpuPkg::OP_INC, codeAr, codeAr, codeR1));
        emit(directWord(cpuPkg::OP_ST, 2'd2));
    end
    emit(branchWord(cpuPkg::OP_BRA, progPc + 8'd4));
    emit(directWord(cpuPkg::OP_ST, 2'd0));      // Skipped
    emit(aluWord(cpuPkg::OP_SUB, codeR3, codeR1, codeR1));
    emit(branchWord(cpuPkg::OP_BNE, 8'hf0));    // Z set, falls through
    emit(aluWord(cpuPkg::OP_INC, codeAr, codeAr, codeR1));
    emit(directWord(cpuPkg::OP_ST, 2'd2));
    emit(branchWord(cpuPkg::OP_BNE, progPc + 8'd4));
    emit(directWord(cpuPkg::OP_ST, 2'd0));      // Skipped
    emit(ldImmWord(2'd3, progPc + 8'd6));
    emit(aluWord(cpuPkg::OP_MOV, codePc, codeR4, codeR1));
    emit(directWord(cpuPkg::OP_ST, 2'd1));      // Skipped
    emit({cpuPkg::OP_PUL, 4'h5, randomByte()});
    emit({cpuPkg::OP_PSH, 4'h7, randomByte()});
    emit(aluWord(cpuPkg::OP_INC, codeAr, codeAr, codeR1));
    emit(directWord(cpuPkg::OP_ST, 2'd3));
    emit(branchWord(cpuPkg::OP_BRA, progPc));   // Closing loop
endtask

function automatic void expectEvent(input logic write, input logic [7:0] addr,
                                    input logic [7:0] data, input int cycle);
    memEventT ev;
    ev.write = write;
    ev.addr  = addr;
    ev.data  = data;
    ev.cycle = cycle;
    expQ.push_back(ev);
endfunction

function automatic logic [7:0] regValue(input logic [2:0] code, input logic [3:0][7:0] gp,
                                        input logic [7:0] arV, input logic [7:0] pcV);
    case (code)
        3'd4:       return 8'h00;
        3'd5:       return arV;
        3'd6, 3'd7: return pcV;
        default:    return gp[code[1:0]];
    endcase
endfunction

// Instruction-level model, one entry per expected memory request
function automatic void runReference(input int count);
    logic [7:0]      rm [`MEM_DEPTH];
    logic [3:0][7:0] gp;
    logic [7:0]      ar;
    logic [7:0]      pc;
    logic [7:0]      nextPc;
    logic [7:0]      a;
    logic [7:0]      b;
    logic [7:0]      res;
    logic [15:0]     ins;
    logic            z;
    logic            isAlu;
    cpuPkg::opcodeE  op;
    int              k;
    rm = mem;
    gp = '0;
    ar = '0;
    pc = '0;
    z  = 1'b0;
    for (k = 0; k < count; k++) begin
        ins = {rm[pc], rm[pc + 8'd1]};
        expectEvent(1'b0, pc, 8'h00, 3 * k);
        expectEvent(1'b0, pc + 8'd1, 8'h00, 3 * k + 1);
        nextPc = pc + 8'd2;
        op     = cpuPkg::opcodeE'(ins[15:12]);
        a      = regValue(ins[6:4], gp, ar, nextPc);     // PC reads as the next address
        b      = regValue(ins[2:0], gp, ar, nextPc);
        isAlu  = 1'b1;
        res    = '0;
        case (op)
            cpuPkg::OP_AND: res = a & b;
            cpuPkg::OP_OR:  res = a | b;
            cpuPkg::OP_NOT: res = ~a;
            cpuPkg::OP_ADD: res = a + b;
            cpuPkg::OP_SUB: res = a - b;
            cpuPkg::OP_LSR: res = {1'b0, a[7:1]};
            cpuPkg::OP_LSL: res = {a[6:0], 1'b0};
            cpuPkg::OP_INC: res = a + 8'd1;
            cpuPkg::OP_DEC: res = a - 8'd1;
            cpuPkg::OP_MOV: res = a;
            default:        isAlu = 1'b0;
        endcase
        if (isAlu) begin
            z = (res == 8'h00);
            if (ins[10:8] == 3'd5) begin
                ar = res;
            end else if (ins[10:9] == 2'b11) begin
                nextPc = res;
            end else if (!ins[10]) begin
                gp[ins[9:8]] = res;
            end
        end else if (op == cpuPkg::OP_BRA && !ins[10]) begin
            nextPc = ins[7:0];
        end else if (op == cpuPkg::OP_BNE && !ins[10] && !z) begin
            nextPc = ins[7:0];
        end else if (op == cpuPkg::OP_LD) begin
            if (ins[10]) begin
                expectEvent(1'b0, ar, 8'h00, 3 * k + 2);
                gp[ins[9:8]] = rm[ar];
            end else begin
                gp[ins[9:8]] = ins[7:0];
            end
        end else if (op == cpuPkg::OP_ST && ins[10]) begin
            expectEvent(1'b1, ar, gp[ins[9:8]], 3 * k + 2);
            rm[ar] = gp[ins[9:8]];
        end
        pc = nextPc;
    end
endfunction

`endif

// ==== test/tbCpu.sv ====
`timescale 1ns/10ps
`include "cpu_params.svh"

module tbCpu;

    typedef struct packed {
        logic        write;
        logic [7:0]  addr;
        logic [7:0]  data;
        logic [31:0] cycle;     // Counted from the first fetch
    } memEventT;

    logic                   clk;
    logic                   rstN;
    logic [`DATA_WIDTH-1:0] memRdData;
    cpuPkg::memReqT         memReq;

    logic [7:0]     mem [`MEM_DEPTH];
    logic [7:0]     progPc;
    int             seed = 32'h443006fc;
    memEventT       expQ [$];
    memEventT       expEvent;
    cpuPkg::memReqT pendingReq;
    int             numInstr;
    int             valueErrors;
    int             otherErrors;
    int             cycleCount;
    int             baseCycle;
    logic           started;
    logic           checkDone;

    `include "tbProgram.svh"

    cpuTop dut (
        .clk       (clk),
        .rstN      (rstN),
        .memRdData (memRdData),
        .memReq    (memReq)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Byte memory, write lands at the edge, read data follows the new address
    initial begin
        memRdData = '0;
        forever begin
            @(negedge clk);
            pendingReq = memReq;
            @(posedge clk);
            #5;
            if (pendingReq.write) begin
                mem[pendingReq.addr] = pendingReq.wrData;
            end
            memRdData = mem[memReq.addr];
        end
    end

    initial begin
        rstN        = 1'b0;
        valueErrors = 0;
        otherErrors = 0;
        cycleCount  = 0;
        baseCycle   = 0;
        started     = 1'b0;
        checkDone   = 1'b0;
        buildProgram();
        numInstr = progPc / 2 + 4;      // A few turns of the closing loop
        runReference(numInstr);
        repeat (16) @(posedge clk);
        #5;
        rstN = 1'b1;
        wait (checkDone);
        @(negedge clk);
        $display("Value errors: %0d, other errors: %0d", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // Compares every memory request against the reference list
    always @(negedge clk) begin
        if (!rstN) begin
            if (memReq.read || memReq.write) begin
                otherErrors++;
                $display("Memory request issued while reset is low");
            end
        end else if (!checkDone) begin
            if (memReq.read && memReq.write) begin
                otherErrors++;
                $display("Read and write requested in the same cycle");
            end else if (memReq.read || memReq.write) begin
                if (!started) begin
                    started   = 1'b1;
                    baseCycle = cycleCount;
                end
                expEvent = expQ.pop_front();
                if (memReq.write !== expEvent.write) begin
                    valueErrors++;
                    $display("** Error memReq.write exp %h got %h", expEvent.write, memReq.write);
                end
                if (memReq.addr !== expEvent.addr) begin
                    valueErrors++;
                    $display("** Error memReq.addr exp %h got %h", expEvent.addr, memReq.addr);
                end
                if (expEvent.write && memReq.wrData !== expEvent.data) begin
                    valueErrors++;
                    $display("** Error memReq.wrData exp %h got %h", expEvent.data,
                             memReq.wrData);
                end
                if (cycleCount - baseCycle != expEvent.cycle) begin
                    valueErrors++;
                    $display("** Error memReq cycle exp %h got %h", expEvent.cycle,
                             cycleCount - baseCycle);
                end
                if (expQ.size() == 0) begin
                    checkDone = 1'b1;
                end
            end
            cycleCount++;
        end
    end

    initial begin
        wait (rstN);
        repeat (numInstr * 3 + 64) @(posedge clk);
        $display("Timeout with %0d expected memory requests never seen", expQ.size());
        $display("Value errors: %0d, other errors: %0d", valueErrors, otherErrors);
        $display("TEST FAIL");
        $finish;
    end

endmodule

// ==== source/cpuTop.sv ====
`timescale 1ns/10ps
`include "cpu_params.svh"

module cpuTop (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic [`DATA_WIDTH-1:0] memRdData,
    output cpuPkg::memReqT         memReq
);

    logic [`DATA_WIDTH-1:0] fetchByte;
    logic                   loadHi;
    logic                   loadLo;
    logic [`DATA_WIDTH-1:0] pc;
    cpuPkg::decodedInstrT   instr;
    logic                   execValid;
    cpuPkg::memReqT         exeMemReq;
    cpuPkg::pcLoadT         pcLoad;

    fetchSequencer fetch (
        .clk       (clk),
        .rstN      (rstN),
        .memRdData (memRdData),
        .exeMemReq (exeMemReq),
        .pcLoad    (pcLoad),
        .memReq    (memReq),
        .fetchByte (fetchByte),
        .loadHi    (loadHi),
        .loadLo    (loadLo),
        .pc        (pc)
    );

    instrBuffer ibuf (
        .clk       (clk),
        .rstN      (rstN),
        .fetchByte (fetchByte),
        .loadHi    (loadHi),
        .loadLo    (loadLo),
        .instr     (instr),
        .execValid (execValid)
    );

    executeUnit exec (
        .clk       (clk),
        .rstN      (rstN),
        .instr     (instr),
        .execValid (execValid),
        .pc        (pc),
        .memRdData (memRdData),   // Direct LD data
        .exeMemReq (exeMemReq),
        .pcLoad    (pcLoad)
    );

endmodule

// ==== source/executeUnit.sv ====
`timescale 1ns/10ps
`include "cpu_params.svh"

module executeUnit (
    input  logic                   clk,
    input  logic                   rstN,
    input  cpuPkg::decodedInstrT   instr,
    input  logic                   execValid,
    input  logic [`DATA_WIDTH-1:0] pc,
    input  logic [`DATA_WIDTH-1:0] memRdData,
    output cpuPkg::memReqT         exeMemReq,
    output cpuPkg::pcLoadT         pcLoad
);

    logic [`DATA_WIDTH-1:0] gpRegs [`NUM_GP_REGS];
    logic [`DATA_WIDTH-1:0] ar;
    logic                   zFlag;

    logic [`DATA_WIDTH-1:0] opA;
    logic [`DATA_WIDTH-1:0] opB;
    logic [`DATA_WIDTH-1:0] aluResult;
    logic                   aluZero;
    cpuPkg::aluOpE          aluOp;
    logic                   isAluInstr;
    logic                   isDirect;
    logic [`DATA_WIDTH-1:0] loadData;

    function automatic logic [`DATA_WIDTH-1:0] readReg(input cpuPkg::regCodeT code);
        logic [`DATA_WIDTH-1:0] value;
        if (!code[2]) begin
            value = gpRegs[code[1:0]];
        end else if (code[1]) begin
            value = pc;             // Codes 6 and 7
        end else if (code[0]) begin
            value = ar;
        end else begin
            value = '0;             // Old SP slot
        end
        return value;
    endfunction

    // Opcode to ALU function
    always_comb begin
        aluOp      = cpuPkg::ALU_PASS;
        isAluInstr = 1'b1;
        case (instr.opcode)
            cpuPkg::OP_AND: aluOp = cpuPkg::ALU_AND;
            cpuPkg::OP_OR:  aluOp = cpuPkg::ALU_OR;
            cpuPkg::OP_NOT: aluOp = cpuPkg::ALU_NOT;
            cpuPkg::OP_ADD: aluOp = cpuPkg::ALU_ADD;
            cpuPkg::OP_SUB: aluOp = cpuPkg::ALU_SUB;
            cpuPkg::OP_LSR: aluOp = cpuPkg::ALU_LSR;
            cpuPkg::OP_LSL: aluOp = cpuPkg::ALU_LSL;
            cpuPkg::OP_INC: aluOp = cpuPkg::ALU_INC;
            cpuPkg::OP_DEC: aluOp = cpuPkg::ALU_DEC;
            cpuPkg::OP_MOV: aluOp = cpuPkg::ALU_PASS;
            default:        isAluInstr = 1'b0;
        endcase
    end

    // Operands follow the register file, AR and PC
    always_comb begin
        opA = readReg(instr.src1);
        opB = readReg(instr.src2);
    end

    assign isDirect = execValid && instr.addrMode;
    assign loadData = instr.addrMode ? memRdData : instr.imm;

    aluCore alu (
        .a      (opA),
        .b      (opB),
        .op     (aluOp),
        .result (aluResult),
        .zero   (aluZero)
    );

    // LD and ST in direct mode go through M[AR]
    always_comb begin
        exeMemReq = '0;
        if (isDirect && (instr.opcode == cpuPkg::OP_LD)) begin
            exeMemReq.addr = ar;
            exeMemReq.read = 1'b1;
        end else if (isDirect && (instr.opcode == cpuPkg::OP_ST)) begin
            exeMemReq.addr   = ar;
            exeMemReq.wrData = gpRegs[instr.regSel];
            exeMemReq.write  = 1'b1;
        end
    end

    always_comb begin
        pcLoad = '0;
        if (execValid) begin
            if (isAluInstr && instr.dest[2] && instr.dest[1]) begin
                pcLoad.load   = 1'b1;   // ALU result to PC
                pcLoad.target = aluResult;
            end else if (!instr.addrMode && ((instr.opcode == cpuPkg::OP_BRA) ||
                         ((instr.opcode == cpuPkg::OP_BNE) && !zFlag))) begin
                pcLoad.load   = 1'b1;
                pcLoad.target = instr.imm;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < `NUM_GP_REGS; i++) begin
                gpRegs[i] <= '0;
            end
            ar    <= '0;
            zFlag <= 1'b0;
        end else if (execValid) begin
            if (isAluInstr) begin
                zFlag <= aluZero;
                if (!instr.dest[2]) begin
                    gpRegs[instr.dest[1:0]] <= aluResult;
                end else if (instr.dest[1:0] == 2'b01) begin
                    ar <= aluResult;
                end
            end else if (instr.opcode == cpuPkg::OP_LD) begin
                gpRegs[instr.regSel] <= loadData;
            end
        end
    end

endmodule

// ==== source/instrBuffer.sv ====
`timescale 1ns/10ps
`include "cpu_params.svh"

module instrBuffer (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic [`DATA_WIDTH-1:0] fetchByte,
    input  logic                   loadHi,
    input  logic                   loadLo,
    output cpuPkg::decodedInstrT   instr,
    output logic                   execValid
);

    logic [`INSTR_WIDTH-1:0] ir;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            ir        <= '0;
            execValid <= 1'b0;
        end else begin
            if (loadHi) begin
                ir[`INSTR_WIDTH-1:`DATA_WIDTH] <= fetchByte;    // High byte first
            end
            if (loadLo) begin
                ir[`DATA_WIDTH-1:0] <= fetchByte;
            end
            execValid <= loadLo;    // Execute in the cycle after the low byte
        end
    end

    // Field split, top bit of each register field is not decoded
    always_comb begin
        instr.opcode   = cpuPkg::opcodeE'(ir[`OPCODE_MSB:`OPCODE_LSB]);
        instr.dest     = ir[`DEST_MSB-1:`DEST_LSB];
        instr.addrMode = ir[`ADDR_MODE_BIT];
        instr.regSel   = ir[`REG_SEL_MSB:`REG_SEL_LSB];
        instr.src1     = ir[`SRC1_MSB-1:`SRC1_LSB];
        instr.src2     = ir[`SRC2_MSB-1:`SRC2_LSB];
        instr.imm      = ir[`IMM_MSB:`IMM_LSB];
    end

endmodule

// ==== source/fetchSequencer.sv ====
`timescale 1ns/10ps
`include "cpu_params.svh"

module fetchSequencer (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic [`DATA_WIDTH-1:0] memRdData,
    input  cpuPkg::memReqT         exeMemReq,
    input  cpuPkg::pcLoadT         pcLoad,
    output cpuPkg::memReqT         memReq,
    output logic [`DATA_WIDTH-1:0] fetchByte,
    output logic                   loadHi,
    output logic                   loadLo,
    output logic [`DATA_WIDTH-1:0] pc
);

    cpuPkg::seqStateE state;
    cpuPkg::seqStateE stateNext;
    logic             running;      // Goes high one cycle after reset release

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state   <= cpuPkg::FETCH_HI;
            running <= 1'b0;
        end else begin
            state   <= stateNext;
            running <= 1'b1;
        end
    end

    always_comb begin
        stateNext = state;
        case (state)
            cpuPkg::FETCH_HI: begin
                if (running) begin
                    stateNext = cpuPkg::FETCH_LO;
                end
            end
            cpuPkg::FETCH_LO: stateNext = cpuPkg::EXECUTE;
            cpuPkg::EXECUTE:  stateNext = cpuPkg::FETCH_HI;
            default:          stateNext = cpuPkg::FETCH_HI;
        endcase
    end

    assign loadHi    = running && (state == cpuPkg::FETCH_HI);
    assign loadLo    = (state == cpuPkg::FETCH_LO);
    assign fetchByte = memRdData;   // Read data is valid in the request cycle

    // PC steps once per fetched byte, branch target lands at the execute edge
    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= '0;
        end else if (loadHi || loadLo) begin
            pc <= pc + 1'b1;
        end else if ((state == cpuPkg::EXECUTE) && pcLoad.load) begin
            pc <= pcLoad.target;
        end
    end

    // Memory port owner
    always_comb begin
        memReq = '0;
        if (state == cpuPkg::EXECUTE) begin
            memReq = exeMemReq;     // Loads and stores from the execute unit
        end else if (loadHi || loadLo) begin
            memReq.addr = pc;
            memReq.read = 1'b1;
        end
    end

endmodule

// ==== source/aluCore.sv ====
`timescale 1ns/10ps
`include "cpu_params.svh"

module aluCore (
    input  logic [`DATA_WIDTH-1:0] a,
    input  logic [`DATA_WIDTH-1:0] b,
    input  cpuPkg::aluOpE          op,
    output logic [`DATA_WIDTH-1:0] result,
    output logic                   zero
);

    always_comb begin
        case (op)
            cpuPkg::ALU_PASS: begin
                result = a;             // MOV
            end
            cpuPkg::ALU_AND: begin
                result = a & b;
            end
            cpuPkg::ALU_OR: begin
                result = a | b;
            end
            cpuPkg::ALU_NOT: begin
                result = ~a;
            end
            cpuPkg::ALU_ADD: begin
                result = a + b;         // Wraps, no carry out
            end
            cpuPkg::ALU_SUB: begin
                result = a - b;
            end
            cpuPkg::ALU_LSR: begin
                result = a >> 1;        // Zero fill
            end
            cpuPkg::ALU_LSL: begin
                result = a << 1;
            end
            cpuPkg::ALU_INC: begin
                result = a + 1'b1;
            end
            cpuPkg::ALU_DEC: begin
                result = a - 1'b1;
            end
            default: begin
                result = a;
            end
        endcase
    end

    assign zero = (result == '0);

endmodule

// ==== source/cpuPkg.sv ====
`include "cpu_params.svh"

package cpuPkg;

    typedef enum logic [3:0] {
        OP_AND = 4'd0,
        OP_OR  = 4'd1,
        OP_NOT = 4'd2,
        OP_ADD = 4'd3,
        OP_SUB = 4'd4,
        OP_LSR = 4'd5,
        OP_LSL = 4'd6,
        OP_INC = 4'd7,
        OP_DEC = 4'd8,
        OP_BRA = 4'd9,
        OP_BNE = 4'd10,
        OP_MOV = 4'd11,
        OP_LD  = 4'd12,
        OP_ST  = 4'd13,
        OP_PUL = 4'd14,     // No-op in this core
        OP_PSH = 4'd15      // No-op in this core
    } opcodeE;

    typedef enum logic [1:0] {
        FETCH_HI,
        FETCH_LO,
        EXECUTE
    } seqStateE;

    typedef enum logic [3:0] {
        ALU_PASS,
        ALU_AND,
        ALU_OR,
        ALU_NOT,
        ALU_ADD,
        ALU_SUB,
        ALU_LSR,
        ALU_LSL,
        ALU_INC,
        ALU_DEC
    } aluOpE;

    // 0-3 R1-R4, 4 reads zero, 5 AR, 6-7 PC
    typedef logic [2:0] regCodeT;

    typedef struct packed {
        opcodeE                                  opcode;
        regCodeT                                 dest;
        logic                                    addrMode;
        logic [`REG_SEL_MSB-`REG_SEL_LSB:0]      regSel;
        regCodeT                                 src1;
        regCodeT                                 src2;
        logic [`IMM_MSB-`IMM_LSB:0]              imm;
    } decodedInstrT;

    typedef struct packed {
        logic [`DATA_WIDTH-1:0] addr;
        logic [`DATA_WIDTH-1:0] wrData;
        logic                   read;
        logic                   write;
    } memReqT;

    typedef struct packed {
        logic                   load;
        logic [`DATA_WIDTH-1:0] target;
    } pcLoadT;

endpackage

// ==== source/cpu_params.svh ====
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

`define DATA_WIDTH    8     // Data and address width
`define INSTR_WIDTH   16
`define NUM_GP_REGS   4     // R1 to R4
`define MEM_DEPTH     256

// Instruction field positions
`define OPCODE_MSB    15
`define OPCODE_LSB    12
`define DEST_MSB      11
`define DEST_LSB      8
`define ADDR_MODE_BIT 10    // Shares bits with dest and regSel
`define REG_SEL_MSB   9
`define REG_SEL_LSB   8
`define SRC1_MSB      7
`define SRC1_LSB      4
`define SRC2_MSB      3
`define SRC2_LSB      0
`define IMM_MSB       7
`define IMM_LSB       0

`endif
